// File: src/vga_pkg.sv
package vga_pkg;

    // horizontal timing in pixel clocks
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    // full line of 800 clocks
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing in lines
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    // full frame of 525 lines
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    // sprite edge in pixels
    localparam int SPRITE_SIZE = 16;

    // raster counters and sprite coordinates
    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;
    typedef logic [8:0] pos_t;

    // one colour channel of the vga connector
    typedef logic [2:0] color_t;

    localparam color_t COLOR_ON  = '1;
    localparam color_t COLOR_OFF = '0;

    // hollow square with a two pixel border
    // index is the sprite row
    // bit c lights column c of that row
    localparam logic [SPRITE_SIZE-1:0] SPRITE_BITMAP [SPRITE_SIZE] = '{
        16'b1111_1111_1111_1111,
        16'b1111_1111_1111_1111,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1100_0000_0000_0011,
        16'b1111_1111_1111_1111,
        16'b1111_1111_1111_1111
    };

endpackage

// File: src/raster_if.sv
`timescale 1ns/100ps

interface raster_if
    import vga_pkg::*;
();

    // raster position of the current pixel
    h_count_t h_count;
    v_count_t v_count;

    // high inside the 640x480 area
    logic     visible;

    // active low sync levels, aligned with the counts above
    logic     hsync_n;
    logic     vsync_n;

    // driving side, one per pipeline stage
    modport source (
        output h_count, v_count, visible, hsync_n, vsync_n
    );

    // consuming side
    modport sink (
        input  h_count, v_count, visible, hsync_n, vsync_n
    );

endinterface

// File: src/vga_timing_gen.sv
`timescale 1ns/100ps

module vga_timing_gen
    import vga_pkg::*;
(
    input  logic     i_Clk,
    input  logic     i_rst_n,
    raster_if.source raster
);

    // free running pixel and line counters
    h_count_t h_cnt;
    v_count_t v_cnt;

    // end of line and end of frame
    logic h_last;
    logic v_last;

    // window decodes taken straight off the counters
    logic h_sync_win;
    logic v_sync_win;
    logic in_visible;

    assign h_last = (h_cnt == h_count_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == v_count_t'(V_TOTAL - 1));

    // hsync window spans pixels 656 to 751
    assign h_sync_win = (h_cnt >= h_count_t'(H_VISIBLE + H_FRONT)) &&
                        (h_cnt <  h_count_t'(H_VISIBLE + H_FRONT + H_SYNC));

    // vsync window spans lines 490 and 491
    assign v_sync_win = (v_cnt >= v_count_t'(V_VISIBLE + V_FRONT)) &&
                        (v_cnt <  v_count_t'(V_VISIBLE + V_FRONT + V_SYNC));

    assign in_visible = (h_cnt < h_count_t'(H_VISIBLE)) &&
                        (v_cnt < v_count_t'(V_VISIBLE));

    // pixel counter wraps every line, line counter every frame
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                // step to next line, wrap at frame end
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // stage 0 register
    // counts go out with their decoded levels, one cycle late
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            raster.h_count <= '0;
            raster.v_count <= '0;
            raster.visible <= 1'b0;
            raster.hsync_n <= 1'b1;
            raster.vsync_n <= 1'b1;
        end else begin
            raster.h_count <= h_cnt;
            raster.v_count <= v_cnt;
            raster.visible <= in_visible;
            // syncs are active low
            raster.hsync_n <= !h_sync_win;
            raster.vsync_n <= !v_sync_win;
        end
    end

endmodule

// File: src/sprite_pos_latch.sv
`timescale 1ns/100ps

module sprite_pos_latch
    import vga_pkg::*;
(
    input  logic   i_Clk,
    input  logic   i_rst_n,
    input  pos_t   i_x_pos,
    input  pos_t   i_y_pos,
    raster_if.sink raster,
    output pos_t   o_sprite_x,
    output pos_t   o_sprite_y
);

    // vsync level from the previous cycle
    logic vsync_n_q;

    // one cycle strobe at the start of vertical sync
    logic vsync_fall;

    assign vsync_fall = vsync_n_q && !raster.vsync_n;

    // edge detect register
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            // idle level, no false edge out of reset
            vsync_n_q <= 1'b1;
        end else begin
            vsync_n_q <= raster.vsync_n;
        end
    end

    // position sampled once per frame
    // vsync starts at line 490, well clear of the visible lines,
    // so the whole next frame sees one position
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            o_sprite_x <= '0;
            o_sprite_y <= '0;
        end else if (vsync_fall) begin
            o_sprite_x <= i_x_pos;
            o_sprite_y <= i_y_pos;
        end
    end

    // inputs are plain levels
    // anything they do between vsync edges is ignored

endmodule

// File: src/sprite_renderer.sv
`timescale 1ns/100ps

module sprite_renderer
    import vga_pkg::*;
(
    input  logic     i_Clk,
    input  logic     i_rst_n,
    input  pos_t     i_sprite_x,
    input  pos_t     i_sprite_y,
    raster_if.sink   raster_in,
    raster_if.source raster_out,
    output logic     o_pixel_on
);

    // bits needed to index one sprite row or column
    localparam int OFF_W = $clog2(SPRITE_SIZE);

    // box corners widened to the counter width
    // x0 + 16 stays below 1024, no overflow
    h_count_t box_x0;
    h_count_t box_x1;
    v_count_t box_y0;
    v_count_t box_y1;

    // offsets of the raster point inside the box
    h_count_t col_diff;
    v_count_t row_diff;
    logic [OFF_W-1:0] col_off;
    logic [OFF_W-1:0] row_off;

    // box hit and bitmap bit
    logic in_box_x;
    logic in_box_y;
    logic bitmap_bit;
    logic pixel_hit;

    assign box_x0 = h_count_t'(i_sprite_x);
    assign box_y0 = v_count_t'(i_sprite_y);
    assign box_x1 = box_x0 + h_count_t'(SPRITE_SIZE);
    assign box_y1 = box_y0 + v_count_t'(SPRITE_SIZE);

    // half open range [x0, x0+16)
    assign in_box_x = (raster_in.h_count >= box_x0) && (raster_in.h_count < box_x1);
    assign in_box_y = (raster_in.v_count >= box_y0) && (raster_in.v_count < box_y1);

    // only the low bits matter once inside the box
    assign col_diff = raster_in.h_count - box_x0;
    assign row_diff = raster_in.v_count - box_y0;
    assign col_off  = col_diff[OFF_W-1:0];
    assign row_off  = row_diff[OFF_W-1:0];

    // row picks the word, column picks the bit
    assign bitmap_bit = SPRITE_BITMAP[row_off][col_off];

    // offsets are junk outside the box, hence the gate
    // box parts past the screen edge are blanked later on
    assign pixel_hit = in_box_x && in_box_y && bitmap_bit;

    // stage 1 control and pixel decision
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            o_pixel_on         <= 1'b0;
            raster_out.visible <= 1'b0;
            raster_out.hsync_n <= 1'b1;
            raster_out.vsync_n <= 1'b1;
        end else begin
            o_pixel_on         <= pixel_hit;
            raster_out.visible <= raster_in.visible;
            raster_out.hsync_n <= raster_in.hsync_n;
            raster_out.vsync_n <= raster_in.vsync_n;
        end
    end

    // counts carried along so the copy stays aligned
    always_ff @(posedge i_Clk) begin
        raster_out.h_count <= raster_in.h_count;
        raster_out.v_count <= raster_in.v_count;
    end

endmodule

// File: src/vga_output_stage.sv
`timescale 1ns/100ps

module vga_output_stage
    import vga_pkg::*;
(
    input  logic   i_Clk,
    input  logic   i_rst_n,
    raster_if.sink raster,
    input  logic   i_pixel_on,
    output logic   o_hsync,
    output logic   o_vsync,
    output color_t o_red,
    output color_t o_grn,
    output color_t o_blu
);

    // lit only inside the visible area
    logic   lit;

    // same level on all three channels, white or black
    color_t pix_color;

    // the only blanking point in the pipe
    assign lit       = i_pixel_on && raster.visible;
    assign pix_color = lit ? COLOR_ON : COLOR_OFF;

    // stage 2, drives the pins
    // sync and colour leave on the same edge
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            o_hsync <= 1'b1;
            o_vsync <= 1'b1;
            o_red   <= COLOR_OFF;
            o_grn   <= COLOR_OFF;
            o_blu   <= COLOR_OFF;
        end else begin
            o_hsync <= raster.hsync_n;
            o_vsync <= raster.vsync_n;
            // monochrome sprite
            o_red   <= pix_color;
            o_grn   <= pix_color;
            o_blu   <= pix_color;
        end
    end

    // raster counts arrive too but are not needed here
    // blanking relies on the visible level alone

endmodule

// File: src/sprite_display_top.sv
`timescale 1ns/100ps

module sprite_display_top
    import vga_pkg::*;
(
    input  logic   i_Clk,
    input  logic   i_rst_n,
    input  pos_t   i_x_pos,
    input  pos_t   i_y_pos,
    output logic   o_vga_hsync,
    output logic   o_vga_vsync,
    output color_t o_vga_red,
    output color_t o_vga_grn,
    output color_t o_vga_blu
);

    // stage 0 raster from the timing generator
    raster_if raster_s0 ();
    // stage 1 copy, aligned with pixel_on
    raster_if raster_s1 ();

    // position held for the current frame
    pos_t sprite_x;
    pos_t sprite_y;

    // sprite covers the stage 1 pixel
    logic pixel_on;

    vga_timing_gen u_timing (
        .i_Clk   (i_Clk),
        .i_rst_n (i_rst_n),
        .raster  (raster_s0)
    );

    sprite_pos_latch u_pos_latch (
        .i_Clk      (i_Clk),
        .i_rst_n    (i_rst_n),
        .i_x_pos    (i_x_pos),
        .i_y_pos    (i_y_pos),
        .raster     (raster_s0),
        .o_sprite_x (sprite_x),
        .o_sprite_y (sprite_y)
    );

    sprite_renderer u_renderer (
        .i_Clk      (i_Clk),
        .i_rst_n    (i_rst_n),
        .i_sprite_x (sprite_x),
        .i_sprite_y (sprite_y),
        .raster_in  (raster_s0),
        .raster_out (raster_s1),
        .o_pixel_on (pixel_on)
    );

    vga_output_stage u_output (
        .i_Clk      (i_Clk),
        .i_rst_n    (i_rst_n),
        .raster     (raster_s1),
        .i_pixel_on (pixel_on),
        .o_hsync    (o_vga_hsync),
        .o_vsync    (o_vga_vsync),
        .o_red      (o_vga_red),
        .o_grn      (o_vga_grn),
        .o_blu      (o_vga_blu)
    );

endmodule

// File: dv/sprite_display_tb.sv
`timescale 1ns/100ps

module sprite_display_tb
    import vga_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // border width of the hollow square
    localparam int BORDER       = 2;
    // lit pixels are full white on every channel
    localparam color_t WHITE = 3'b111;
    localparam color_t BLACK = 3'b000;

    logic   i_Clk;
    logic   i_rst_n;
    pos_t   i_x_pos;
    pos_t   i_y_pos;
    logic   o_vga_hsync;
    logic   o_vga_vsync;
    color_t o_vga_red;
    color_t o_vga_grn;
    color_t o_vga_blu;

    // own raster position locked to the first vsync fall
    logic locked = 1'b0;
    int   px = 0;
    int   ln = 0;
    int   frame_cnt = 0;
    // position applied when vsync fell
    // it governs the next frame
    int   fx = 0;
    int   fy = 0;
    // sync measurement
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    int   cyc = 0;
    int   hs_fall_cyc = -1;
    int   vs_fall_cyc = -1;
    int   hs_widths = 0;
    int   vs_widths = 0;
    int   vs_periods = 0;
    int   blank_lit = 0;
    // colour seen at the box corner and centre in each frame
    int   corner_lit [8] = '{default: -1};
    int   centre_lit [8] = '{default: -1};
    // error and test counts
    int   pix_errs = 0;
    int   sync_errs = 0;
    int   seq_errs = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    logic [31:0] rng_state = 32'd98403;

    sprite_display_top DUT (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_x_pos     (i_x_pos),
        .i_y_pos     (i_y_pos),
        .o_vga_hsync (o_vga_hsync),
        .o_vga_vsync (o_vga_vsync),
        .o_vga_red   (o_vga_red),
        .o_vga_grn   (o_vga_grn),
        .o_vga_blu   (o_vga_blu)
    );

    initial i_Clk = 1'b0;
    always #(CLK_PERIOD / 2) i_Clk = ~i_Clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // reference for pixel (x, y) with the sprite box at (sx, sy)
    // lit only on the two pixel border of the hollow square
    function automatic logic expected_on(input int x, input int y, input int sx, input int sy);
        int   r;
        int   c;
        logic hit;
        r = y - sy;
        c = x - sx;
        hit = 1'b0;
        // blanking clips the box at the screen edges
        if (x < H_VISIBLE && y < V_VISIBLE && c >= 0 && c < SPRITE_SIZE &&
            r >= 0 && r < SPRITE_SIZE) begin
            hit = (r < BORDER) || (r >= SPRITE_SIZE - BORDER) ||
                  (c < BORDER) || (c >= SPRITE_SIZE - BORDER);
        end
        return hit;
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    // new position 10 ns after the clock edge
    task automatic apply_position(input int x, input int y);
        @(posedge i_Clk);
        #10;
        i_x_pos = pos_t'(x);
        i_y_pos = pos_t'(y);
    endtask

    task automatic check_idle(input string when);
        if (o_vga_hsync !== 1'b1 || o_vga_vsync !== 1'b1 || o_vga_red !== BLACK ||
            o_vga_grn !== BLACK || o_vga_blu !== BLACK) begin
            seq_errs++;
            report_fail($sformatf("outputs not idle %s: hs %b vs %b rgb %0d/%0d/%0d", when,
                o_vga_hsync, o_vga_vsync, o_vga_red, o_vga_grn, o_vga_blu));
        end
    endtask

    // comparison process samples mid cycle
    always @(negedge i_Clk) begin
        color_t exp_col;
        if (i_rst_n) begin
            cyc++;
            if (locked) begin
                if (px == H_TOTAL - 1) begin
                    px = 0;
                    ln = (ln == V_TOTAL - 1) ? 0 : ln + 1;
                end else begin
                    px++;
                end
            end
            // vsync falls at output line 490 pixel 0
            if (prev_vs && !o_vga_vsync) begin
                if (!locked) begin
                    locked = 1'b1;
                    px = 0;
                    ln = V_VISIBLE + V_FRONT;
                end else begin
                    if (px != 0 || ln != V_VISIBLE + V_FRONT) begin
                        sync_errs++;
                        report_fail($sformatf("vsync fell at pixel %0d line %0d", px, ln));
                    end
                    if (cyc - vs_fall_cyc != FRAME_CYCLES) begin
                        sync_errs++;
                        report_fail($sformatf("vsync period %0d", cyc - vs_fall_cyc));
                    end
                    vs_periods++;
                end
                vs_fall_cyc = cyc;
                frame_cnt++;
                fx = i_x_pos;
                fy = i_y_pos;
            end
            if (locked && !prev_vs && o_vga_vsync) begin
                if (cyc - vs_fall_cyc != V_SYNC * H_TOTAL) begin
                    sync_errs++;
                    report_fail($sformatf("vsync low for %0d cycles", cyc - vs_fall_cyc));
                end
                vs_widths++;
            end
            if (locked && prev_hs && !o_vga_hsync) begin
                // sync pulse starts after visible area and front porch
                if (px != H_VISIBLE + H_FRONT) begin
                    sync_errs++;
                    report_fail($sformatf("hsync fell at pixel %0d", px));
                end
                if (hs_fall_cyc >= 0 && cyc - hs_fall_cyc != H_TOTAL) begin
                    sync_errs++;
                    report_fail($sformatf("hsync period %0d", cyc - hs_fall_cyc));
                end
                hs_fall_cyc = cyc;
            end
            if (locked && !prev_hs && o_vga_hsync && hs_fall_cyc >= 0) begin
                if (cyc - hs_fall_cyc != H_SYNC) begin
                    sync_errs++;
                    report_fail($sformatf("hsync low for %0d cycles", cyc - hs_fall_cyc));
                end
                hs_widths++;
            end
            if (locked) begin
                exp_col = expected_on(px, ln, fx, fy) ? WHITE : BLACK;
                if (o_vga_red !== exp_col || o_vga_grn !== exp_col || o_vga_blu !== exp_col) begin
                    pix_errs++;
                    report_fail($sformatf("pixel (%0d,%0d) rgb %0d/%0d/%0d, expected %0d",
                        px, ln, o_vga_red, o_vga_grn, o_vga_blu, exp_col));
                end
                if ((px >= H_VISIBLE || ln >= V_VISIBLE) &&
                    (o_vga_red | o_vga_grn | o_vga_blu) != BLACK) begin
                    blank_lit++;
                end
                if (frame_cnt < 8 && px == fx && ln == fy) begin
                    corner_lit[frame_cnt] = (o_vga_red === WHITE);
                end
                if (frame_cnt < 8 && px == fx + 7 && ln == fy + 7) begin
                    centre_lit[frame_cnt] = (o_vga_red === WHITE);
                end
            end
            prev_hs = o_vga_hsync;
            prev_vs = o_vga_vsync;
        end
    end

    // watchdog over eight frame times
    initial begin
        #(8 * FRAME_CYCLES * CLK_PERIOD);
        $display("Timeout: the display did not reach the end of the test sequence");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int base;
        int rx;
        int ry;
        i_rst_n = 1'b0;
        i_x_pos = '0;
        i_y_pos = '0;

        // reset state
        base = seq_errs;
        repeat (15) begin
            @(negedge i_Clk);
            check_idle("during reset");
        end
        @(posedge i_Clk);
        #10;
        i_rst_n = 1'b1;
        @(negedge i_Clk);
        check_idle("at release");
        @(negedge i_Clk);
        check_idle("first cycle after reset");
        finish_test("reset state", seq_errs - base);

        // sprite drawing with frame 1 at (100,100)
        apply_position(100, 100);
        wait (frame_cnt == 1);
        base = pix_errs + seq_errs;
        // frame 2 then draws at line 400, after this mid frame change
        wait (frame_cnt == 1 && ln == 240);
        apply_position(200, 400);
        wait (frame_cnt == 2);
        if (corner_lit[1] != 1 || centre_lit[1] != 0) begin
            seq_errs++;
            report_fail($sformatf("frame 1 corner %0d centre %0d", corner_lit[1], centre_lit[1]));
        end
        finish_test("sprite drawing", pix_errs + seq_errs - base);

        // frame-synchronous update with a change midway through frame 2
        base = pix_errs + seq_errs;
        wait (frame_cnt == 2 && ln == 240);
        apply_position(300, 50);
        wait (frame_cnt == 3);
        if (vs_periods < 2 || vs_widths < 2 || hs_widths < 2 * (V_TOTAL - 1)) begin
            sync_errs++;
            $display("too few sync pulses seen: hs %0d vs %0d", hs_widths, vs_widths);
        end
        finish_test("sync timing", sync_errs);
        // first clipped box crosses the bottom edge
        // 9-bit x tops out at 511 so only y can cross
        wait (frame_cnt == 3 && ln == 240);
        apply_position(511, 470);
        wait (frame_cnt == 4);
        if (corner_lit[2] != 1 || corner_lit[3] != 1) begin
            seq_errs++;
            report_fail($sformatf("frame 2/3 corners %0d/%0d", corner_lit[2], corner_lit[3]));
        end
        finish_test("frame update", pix_errs + seq_errs - base);

        // random positions and clipping over frames 4 to 6
        base = pix_errs + seq_errs;
        wait (frame_cnt == 4 && ln == 240);
        rng_state = xorshift32(rng_state);
        apply_position(int'(rng_state[8:0]), int'(rng_state[17:9]));
        wait (frame_cnt == 5 && ln == 240);
        rng_state = xorshift32(rng_state);
        rx = int'(rng_state[8:0]);
        // y forced to cross the bottom edge
        ry = 465 + int'(rng_state[21:18]) % 15;
        apply_position(rx, ry);
        wait (frame_cnt == 7);
        if (blank_lit != 0 || corner_lit[4] != 1) begin
            seq_errs++;
            report_fail($sformatf("%0d lit blanking pixels, clipped corner %0d",
                blank_lit, corner_lit[4]));
        end
        finish_test("random and clipping", pix_errs + seq_errs - base);

        $display("%0d tests run, %0d passed, %0d failed", tests_run,
            tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && pix_errs + sync_errs + seq_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
src/vga_pkg.sv
src/raster_if.sv
src/vga_timing_gen.sv
src/sprite_pos_latch.sv
src/sprite_renderer.sv
src/vga_output_stage.sv
src/sprite_display_top.sv
dv/sprite_display_tb.sv

// File: Bender.yml
package:
  name: sprite_display

sources:
  - files:
      - src/vga_pkg.sv
      - src/raster_if.sv
      - src/vga_timing_gen.sv
      - src/sprite_pos_latch.sv
      - src/sprite_renderer.sv
      - src/vga_output_stage.sv
      - src/sprite_display_top.sv
  - target: simulation
    files:
      - dv/sprite_display_tb.sv
